//--- source/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data path and address width
`define DATA_W 32

// register index width
`define REG_ADDR_W 5

// opcode and funct field width
`define OPCODE_W 6

// immediate and jump index widths
`define IMM_W 16
`define JUMP_IDX_W 26

// testbench memory size in words
`define MEM_WORDS 1024

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

//--- source/mipsPkg.sv
`include "mips_macros.svh"

package mipsPkg;

	typedef enum logic [`OPCODE_W-1:0]
	{
		opRType = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcode_t;

	typedef enum logic [`OPCODE_W-1:0]
	{
		functNop   = 6'h00,
		functBreak = 6'h0d,
		functAdd   = 6'h20,
		functSub   = 6'h22,
		functAnd   = 6'h24,
		functXor   = 6'h26
	} funct_t;

	typedef enum logic [2:0]
	{
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluXor,
		aluLui
	} aluOp_t;

	typedef enum logic [1:0]
	{
		srcBReg,
		srcBFour,
		srcBImm,
		srcBImmShift // sign-extended imm16 times four
	} aluSrcB_t;

	typedef enum logic [1:0]
	{
		pcSrcAlu,
		pcSrcAluOut,
		pcSrcJump
	} pcSource_t;

	typedef enum logic [1:0]
	{
		brNone,
		brEq,
		brNe
	} branchCond_t;

	typedef enum logic [3:0]
	{
		stReset,
		stFetch,
		stDecode,
		stExecR,
		stExecImm,
		stMemAddr,
		stMemRead,
		stMemWrite,
		stWriteback,
		stBranch,
		stJump,
		stHalt
	} state_t;

	typedef struct packed
	{
		logic        pcWrite;
		branchCond_t branchCond;
		pcSource_t   pcSource;
		logic        memRead;
		logic        memWrite;
		logic        iorD;       // 1 selects ALUOut as bus address
		logic        irWrite;
		logic        regWrite;
		logic        regDst;     // 1 selects rd
		logic        memToReg;   // 1 selects MDR
		aluOp_t      aluOp;
		logic        aluSrcA;    // 1 selects A, 0 selects PC
		aluSrcB_t    aluSrcB;
		logic        aluOutLoad;
	} ctrl_t;

	typedef struct packed
	{
		logic [`DATA_W-1:0] paddr;
		logic [`DATA_W-1:0] pwdata;
		logic               psel;
		logic               penable;
		logic               pwrite;
	} apbReq_t;

	typedef struct packed
	{
		logic [`DATA_W-1:0] prdata;
		logic               pready;
	} apbRsp_t;

	// low half of the word, R-type view
	typedef struct packed
	{
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] shamt;
		funct_t                 funct;
	} rFields_t;

	// low half of the word, either R-type fields or imm16
	typedef union packed
	{
		rFields_t           r;
		logic [`IMM_W-1:0]  imm16;
	} lowFields_t;

	typedef struct packed
	{
		opcode_t                opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		lowFields_t             low;
	} instrFields_t;

endpackage : mipsPkg

//--- source/mipsControl.sv
`timescale 1ns/1ps

module mipsControl
(
	input  logic                  Clk,
	input  logic                  arstN,
	input  mipsPkg::instrFields_t instr,
	input  logic                  busDone,
	output mipsPkg::ctrl_t        ctrl,
	output logic                  halted
);

	mipsPkg::state_t state;
	mipsPkg::state_t nextState;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			state <= mipsPkg::stReset;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			mipsPkg::stReset:
				nextState = mipsPkg::stFetch;
			mipsPkg::stFetch:
				if (busDone)
					nextState = mipsPkg::stDecode;
			mipsPkg::stDecode:
			begin
				case (instr.opcode)
					mipsPkg::opRType:
					begin
						case (instr.low.r.funct)
							mipsPkg::functAdd,
							mipsPkg::functSub,
							mipsPkg::functAnd,
							mipsPkg::functXor:
								nextState = mipsPkg::stExecR;
							mipsPkg::functBreak:
								nextState = mipsPkg::stHalt;
							default:
								nextState = mipsPkg::stFetch; // nop and unknown funct
						endcase
					end
					mipsPkg::opBeq,
					mipsPkg::opBne:
						nextState = mipsPkg::stBranch;
					mipsPkg::opLw,
					mipsPkg::opSw:
						nextState = mipsPkg::stMemAddr;
					mipsPkg::opLui:
						nextState = mipsPkg::stExecImm;
					mipsPkg::opJ:
						nextState = mipsPkg::stJump;
					default:
						nextState = mipsPkg::stFetch; // unknown opcode, no effect
				endcase
			end
			mipsPkg::stExecR,
			mipsPkg::stExecImm:
				nextState = mipsPkg::stWriteback;
			mipsPkg::stMemAddr:
				if (instr.opcode == mipsPkg::opLw)
					nextState = mipsPkg::stMemRead;
				else
					nextState = mipsPkg::stMemWrite;
			mipsPkg::stMemRead:
				if (busDone)
					nextState = mipsPkg::stWriteback;
			mipsPkg::stMemWrite:
				if (busDone)
					nextState = mipsPkg::stFetch;
			mipsPkg::stWriteback,
			mipsPkg::stBranch,
			mipsPkg::stJump:
				nextState = mipsPkg::stFetch;
			mipsPkg::stHalt:
				nextState = mipsPkg::stHalt; // left only by reset
			default:
				nextState = mipsPkg::stFetch;
		endcase
	end

	always_comb
	begin
		ctrl = '0;
		ctrl.branchCond = mipsPkg::brNone;
		ctrl.pcSource = mipsPkg::pcSrcAlu;
		ctrl.aluOp = mipsPkg::aluPass;
		ctrl.aluSrcB = mipsPkg::srcBReg;
		case (state)
			mipsPkg::stFetch:
			begin
				ctrl.memRead = 1'b1;
				ctrl.irWrite = 1'b1;
				ctrl.aluOp = mipsPkg::aluAdd;     // pc + 4
				ctrl.aluSrcB = mipsPkg::srcBFour;
				ctrl.pcWrite = busDone;           // step pc once, with the IR load
			end
			mipsPkg::stDecode:
			begin
				ctrl.aluOp = mipsPkg::aluAdd;         // branch target into ALUOut
				ctrl.aluSrcB = mipsPkg::srcBImmShift;
				ctrl.aluOutLoad = 1'b1;
			end
			mipsPkg::stExecR:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOutLoad = 1'b1;
				case (instr.low.r.funct)
					mipsPkg::functAdd: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::functSub: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::functAnd: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::functXor: ctrl.aluOp = mipsPkg::aluXor;
					default:           ctrl.aluOp = mipsPkg::aluPass;
				endcase
			end
			mipsPkg::stExecImm:
			begin
				ctrl.aluOp = mipsPkg::aluLui;
				ctrl.aluOutLoad = 1'b1;
			end
			mipsPkg::stMemAddr:
			begin
				ctrl.aluSrcA = 1'b1;           // rs + sign-extended imm16
				ctrl.aluOp = mipsPkg::aluAdd;
				ctrl.aluSrcB = mipsPkg::srcBImm;
				ctrl.aluOutLoad = 1'b1;
			end
			mipsPkg::stMemRead:
			begin
				ctrl.memRead = 1'b1;
				ctrl.iorD = 1'b1;
			end
			mipsPkg::stMemWrite:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.iorD = 1'b1;
			end
			mipsPkg::stWriteback:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = (instr.opcode == mipsPkg::opRType);
				ctrl.memToReg = (instr.opcode == mipsPkg::opLw);
			end
			mipsPkg::stBranch:
			begin
				ctrl.aluSrcA = 1'b1;          // A - B for the zero flag
				ctrl.aluOp = mipsPkg::aluSub;
				ctrl.pcSource = mipsPkg::pcSrcAluOut;
				if (instr.opcode == mipsPkg::opBne)
					ctrl.branchCond = mipsPkg::brNe;
				else
					ctrl.branchCond = mipsPkg::brEq;
			end
			mipsPkg::stJump:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = mipsPkg::pcSrcJump;
			end
			default:
			begin
				ctrl.aluOp = mipsPkg::aluPass; // reset and halt drive no strobes
			end
		endcase
	end

	assign halted = (state == mipsPkg::stHalt);

endmodule : mipsControl

//--- source/regFile.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module regFile
(
	input  logic                  Clk,
	input  logic                  arstN,
	input  mipsPkg::ctrl_t        ctrl,
	input  mipsPkg::instrFields_t instr,
	input  logic [`DATA_W-1:0]    aluOut,
	input  logic [`DATA_W-1:0]    mdr,
	output logic [`DATA_W-1:0]    a,
	output logic [`DATA_W-1:0]    b
);

	logic [`DATA_W-1:0]    regs [2**`REG_ADDR_W];
	logic [`REG_ADDR_W-1:0] wrAddr;
	logic [`DATA_W-1:0]    wrData;

	assign wrAddr = ctrl.regDst ? instr.low.r.rd : instr.rt;
	assign wrData = ctrl.memToReg ? mdr : aluOut;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 2**`REG_ADDR_W; i++)
				regs[i] <= '0;
		end
		else if (ctrl.regWrite && wrAddr != '0) // r0 never written
			regs[wrAddr] <= wrData;
	end

	// operand latches follow the IR, valid from decode on
	always_ff @(posedge Clk)
	begin
		a <= regs[instr.rs];
		b <= regs[instr.rt];
	end

endmodule : regFile

//--- source/alu.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module alu
(
	input  logic                  Clk,
	input  logic                  arstN,
	input  mipsPkg::ctrl_t        ctrl,
	input  mipsPkg::instrFields_t instr,
	input  logic [`DATA_W-1:0]    pc,
	input  logic [`DATA_W-1:0]    a,
	input  logic [`DATA_W-1:0]    b,
	output logic [`DATA_W-1:0]    aluResult,
	output logic [`DATA_W-1:0]    aluOut,
	output logic                  aluZero
);

	logic [`DATA_W-1:0] srcA;
	logic [`DATA_W-1:0] srcB;
	logic [`DATA_W-1:0] immExt;

	assign immExt = {{(`DATA_W-`IMM_W){instr.low.imm16[`IMM_W-1]}}, instr.low.imm16};
	assign srcA = ctrl.aluSrcA ? a : pc;

	always_comb
	begin
		case (ctrl.aluSrcB)
			mipsPkg::srcBReg:      srcB = b;
			mipsPkg::srcBFour:     srcB = `DATA_W'd4;
			mipsPkg::srcBImm:      srcB = immExt;
			mipsPkg::srcBImmShift: srcB = immExt << 2; // word offset to bytes
			default:               srcB = b;
		endcase
	end

	always_comb
	begin
		case (ctrl.aluOp)
			mipsPkg::aluAdd: aluResult = srcA + srcB;
			mipsPkg::aluSub: aluResult = srcA - srcB;
			mipsPkg::aluAnd: aluResult = srcA & srcB;
			mipsPkg::aluXor: aluResult = srcA ^ srcB;
			mipsPkg::aluLui: aluResult = {instr.low.imm16, {(`DATA_W-`IMM_W){1'b0}}};
			default:         aluResult = srcB;
		endcase
	end

	assign aluZero = (aluResult == '0);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			aluOut <= '0;
		else if (ctrl.aluOutLoad)
			aluOut <= aluResult;
	end

endmodule : alu

//--- source/pcUnit.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module pcUnit
(
	input  logic                  Clk,
	input  logic                  arstN,
	input  mipsPkg::ctrl_t        ctrl,
	input  mipsPkg::instrFields_t instr,
	input  logic [`DATA_W-1:0]    aluResult,
	input  logic [`DATA_W-1:0]    aluOut,
	input  logic                  aluZero,
	output logic [`DATA_W-1:0]    pc
);

	logic [`DATA_W-1:0] jumpTarget;
	logic [`DATA_W-1:0] nextPc;
	logic               branchTaken;

	// pc already holds pc+4 here
	assign jumpTarget = {pc[`DATA_W-1 -: 4], instr.rs, instr.rt, instr.low, 2'b00};

	assign branchTaken = (ctrl.branchCond == mipsPkg::brEq &&  aluZero)
	                  || (ctrl.branchCond == mipsPkg::brNe && !aluZero);

	always_comb
	begin
		case (ctrl.pcSource)
			mipsPkg::pcSrcAlu:    nextPc = aluResult;
			mipsPkg::pcSrcAluOut: nextPc = aluOut;     // branch target from decode
			mipsPkg::pcSrcJump:   nextPc = jumpTarget;
			default:              nextPc = aluResult;
		endcase
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			pc <= `RESET_PC;
		else if (ctrl.pcWrite || branchTaken)
			pc <= nextPc;
	end

endmodule : pcUnit

//--- source/busUnit.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module busUnit
(
	input  logic                  Clk,
	input  logic                  arstN,
	input  mipsPkg::ctrl_t        ctrl,
	input  logic [`DATA_W-1:0]    pc,
	input  logic [`DATA_W-1:0]    aluOut,
	input  logic [`DATA_W-1:0]    b,
	input  mipsPkg::apbRsp_t      apbRsp,
	output mipsPkg::apbReq_t      apbReq,
	output mipsPkg::instrFields_t instr,
	output logic [`DATA_W-1:0]    mdr,
	output logic                  busDone
);

	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [`DATA_W-1:0] paddr;
	logic [`DATA_W-1:0] pwdata;
	logic               reqValid;

	assign reqValid = ctrl.memRead || ctrl.memWrite;
	assign busDone = psel && penable && apbRsp.pready; // access phase ends

	// psel and penable encode idle, setup and access
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			psel <= 1'b0;
			penable <= 1'b0;
			pwrite <= 1'b0;
		end
		else if (!psel)
		begin
			if (reqValid)
			begin
				psel <= 1'b1;          // setup phase
				pwrite <= ctrl.memWrite;
			end
		end
		else if (!penable)
			penable <= 1'b1;           // access phase
		else if (apbRsp.pready)
		begin
			psel <= 1'b0;
			penable <= 1'b0;
			pwrite <= 1'b0;
		end
	end

	// address and data latched at setup, held through the access phase
	always_ff @(posedge Clk)
	begin
		if (!psel && reqValid)
		begin
			paddr <= ctrl.iorD ? aluOut : pc;
			pwdata <= b;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (busDone && !pwrite)
		begin
			if (ctrl.irWrite)
				instr <= mipsPkg::instrFields_t'(apbRsp.prdata);
			else
				mdr <= apbRsp.prdata;
		end
	end

	assign apbReq.paddr = paddr;
	assign apbReq.pwdata = pwdata;
	assign apbReq.psel = psel;
	assign apbReq.penable = penable;
	assign apbReq.pwrite = pwrite;

endmodule : busUnit

//--- source/mipsCore.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCore
(
	input  logic             Clk,
	input  logic             arstN,
	output mipsPkg::apbReq_t apbReq,
	input  mipsPkg::apbRsp_t apbRsp,
	output logic             halted
);

	mipsPkg::ctrl_t        ctrl;
	mipsPkg::instrFields_t instr;
	logic                  busDone;
	logic [`DATA_W-1:0]    pc;
	logic [`DATA_W-1:0]    a;
	logic [`DATA_W-1:0]    b;
	logic [`DATA_W-1:0]    aluResult;
	logic [`DATA_W-1:0]    aluOut;
	logic                  aluZero;
	logic [`DATA_W-1:0]    mdr;

	mipsControl uControl
	(
		.Clk     (Clk),
		.arstN   (arstN),
		.instr   (instr),
		.busDone (busDone),
		.ctrl    (ctrl),
		.halted  (halted)
	);

	regFile uRegFile
	(
		.Clk    (Clk),
		.arstN  (arstN),
		.ctrl   (ctrl),
		.instr  (instr),
		.aluOut (aluOut),
		.mdr    (mdr),
		.a      (a),
		.b      (b)
	);

	alu uAlu
	(
		.Clk       (Clk),
		.arstN     (arstN),
		.ctrl      (ctrl),
		.instr     (instr),
		.pc        (pc),
		.a         (a),
		.b         (b),
		.aluResult (aluResult),
		.aluOut    (aluOut),
		.aluZero   (aluZero)
	);

	pcUnit uPcUnit
	(
		.Clk       (Clk),
		.arstN     (arstN),
		.ctrl      (ctrl),
		.instr     (instr),
		.aluResult (aluResult),
		.aluOut    (aluOut),
		.aluZero   (aluZero),
		.pc        (pc)
	);

	busUnit uBusUnit
	(
		.Clk     (Clk),
		.arstN   (arstN),
		.ctrl    (ctrl),
		.pc      (pc),
		.aluOut  (aluOut),
		.b       (b),
		.apbRsp  (apbRsp),
		.apbReq  (apbReq),
		.instr   (instr),
		.mdr     (mdr),
		.busDone (busDone)
	);

endmodule : mipsCore

//--- verif/mipsChecker.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsChecker
(
	input  logic             Clk,
	input  logic             arstN,
	input  mipsPkg::apbReq_t apbReq,
	input  mipsPkg::apbRsp_t apbRsp,
	input  logic             halted,
	output int               errorCount,
	output int               checkCount,
	output int               fetchCount,
	output logic             breakSeen
);

	typedef enum logic [1:0]
	{
		expFetch,
		expLoad,
		expStore,
		expNone // after BREAK
	} phase_t;

	logic [`DATA_W-1:0] regs [32];
	logic [`DATA_W-1:0] modelPc;
	logic [`DATA_W-1:0] pendAddr;
	logic [`DATA_W-1:0] pendData;
	logic [4:0]         pendRt;
	phase_t             phase;
	int                 sinceBreak;
	logic               haltEarlyReported;
	mipsPkg::apbReq_t   prevReq;
	logic               prevPready;

	assign breakSeen = (phase == expNone);

	task automatic checkValue(input string name, input logic [`DATA_W-1:0] expected,
		input logic [`DATA_W-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic reportError(input string what);
		errorCount++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	task automatic resetModel();
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		modelPc = `RESET_PC;
		phase = expFetch;
		sinceBreak = 0;
		haltEarlyReported = 1'b0;
		prevReq = '0;
		prevPready = 1'b0;
	endtask

	task automatic writeReg(input logic [4:0] idx, input logic [`DATA_W-1:0] value);
		if (idx != 5'd0) // r0 stays zero
			regs[idx] = value;
	endtask

	// runs one ISA instruction on the fetched word
	task automatic executeInstr(input logic [`DATA_W-1:0] word);
		logic [5:0]         op;
		logic [5:0]         funct;
		logic [4:0]         rs;
		logic [4:0]         rt;
		logic [4:0]         rd;
		logic [`DATA_W-1:0] srcS;
		logic [`DATA_W-1:0] srcT;
		logic [`DATA_W-1:0] simm;
		logic [`DATA_W-1:0] nextPc;
		op = word[31:26];
		rs = word[25:21];
		rt = word[20:16];
		rd = word[15:11];
		funct = word[5:0];
		srcS = regs[rs];
		srcT = regs[rt];
		simm = {{16{word[15]}}, word[15:0]};
		nextPc = modelPc + 32'd4;
		case (op)
			mipsPkg::opRType:
				case (funct)
					mipsPkg::functAdd:   writeReg(rd, srcS + srcT);
					mipsPkg::functSub:   writeReg(rd, srcS - srcT);
					mipsPkg::functAnd:   writeReg(rd, srcS & srcT);
					mipsPkg::functXor:   writeReg(rd, srcS ^ srcT);
					mipsPkg::functBreak: phase = expNone;
					default:             ; // nop
				endcase
			mipsPkg::opBeq:
				if (srcS == srcT)
					nextPc = nextPc + (simm << 2);
			mipsPkg::opBne:
				if (srcS != srcT)
					nextPc = nextPc + (simm << 2);
			mipsPkg::opLw:
			begin
				pendAddr = srcS + simm;
				pendRt = rt;
				phase = expLoad;
			end
			mipsPkg::opSw:
			begin
				pendAddr = srcS + simm;
				pendData = srcT;
				phase = expStore;
			end
			mipsPkg::opLui: writeReg(rt, {word[15:0], 16'h0000});
			mipsPkg::opJ:   nextPc = {nextPc[31:28], word[25:0], 2'b00};
			default:        ; // unknown opcode has no effect
		endcase
		sinceBreak = 0;
		modelPc = nextPc;
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		fetchCount = 0;
		resetModel();
	end

	always @(posedge Clk)
	begin
		if (!arstN)
		begin
			checkValue("psel", 1'b0, apbReq.psel);
			checkValue("penable", 1'b0, apbReq.penable);
			checkValue("halted", 1'b0, halted);
			resetModel();
		end
		else
		begin
			if (apbReq.penable && !apbReq.psel)
				reportError("penable is high while psel is low");
			if (apbReq.penable && !prevReq.penable && !prevReq.psel)
				reportError("penable rose without psel set a cycle earlier");
			if (prevReq.psel && !prevReq.penable && !apbReq.penable)
				reportError("setup phase was not followed by an access phase");
			if (prevReq.psel && (!prevReq.penable || !prevPready)) // transfer still open
			begin
				checkValue("paddr", prevReq.paddr, apbReq.paddr);
				checkValue("pwrite", prevReq.pwrite, apbReq.pwrite);
				checkValue("pwdata", prevReq.pwdata, apbReq.pwdata);
			end
			if (phase == expNone)
			begin
				if (apbReq.psel && !prevReq.psel)
					reportError("an APB access started after BREAK");
				if (sinceBreak < 2)
					sinceBreak++;
				checkValue("halted", (sinceBreak == 2), halted); // high from the cycle after decode
			end
			else if (halted && !haltEarlyReported)
			begin
				reportError("halted rose before BREAK was fetched");
				haltEarlyReported = 1'b1;
			end
			if (apbReq.psel && apbReq.penable && apbRsp.pready)
			begin
				case (phase)
					expFetch:
					begin
						checkValue("pwrite", 1'b0, apbReq.pwrite);
						checkValue("paddr", modelPc, apbReq.paddr);
						fetchCount++;
						executeInstr(apbRsp.prdata);
					end
					expLoad:
					begin
						checkValue("pwrite", 1'b0, apbReq.pwrite);
						checkValue("paddr", pendAddr, apbReq.paddr);
						writeReg(pendRt, apbRsp.prdata);
						phase = expFetch;
					end
					expStore:
					begin
						checkValue("pwrite", 1'b1, apbReq.pwrite);
						checkValue("paddr", pendAddr, apbReq.paddr);
						checkValue("pwdata", pendData, apbReq.pwdata);
						phase = expFetch;
					end
					default:
						; // reported at its setup phase
				endcase
			end
			prevReq = apbReq;
			prevPready = apbRsp.pready;
		end
	end

endmodule : mipsChecker

//--- verif/tbMipsCore.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module tbMipsCore;

	localparam int ProgLen = 40;
	localparam int DataBase = 512;    // first word of the data region
	localparam int WaitSlots = 64;
	localparam int HaltTimeout = 5000;

	logic             Clk;
	logic             arstN;
	mipsPkg::apbReq_t apbReq;
	mipsPkg::apbRsp_t apbRsp;
	logic             halted;

	logic [`DATA_W-1:0] mem [`MEM_WORDS];
	int                 waitPattern [WaitSlots];
	int                 waitIdx;
	int                 waitLeft;
	int                 tbErrors;
	int                 cycles;
	int unsigned        seed;
	int                 errorCount;
	int                 checkCount;
	int                 fetchCount;
	logic               breakSeen;

	mipsCore dut
	(
		.Clk    (Clk),
		.arstN  (arstN),
		.apbReq (apbReq),
		.apbRsp (apbRsp),
		.halted (halted)
	);

	mipsChecker uChecker
	(
		.Clk        (Clk),
		.arstN      (arstN),
		.apbReq     (apbReq),
		.apbRsp     (apbRsp),
		.halted     (halted),
		.errorCount (errorCount),
		.checkCount (checkCount),
		.fetchCount (fetchCount),
		.breakSeen  (breakSeen)
	);

	always #20 Clk = ~Clk;

	function automatic logic [31:0] rTypeWord(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {mipsPkg::opRType, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] immWord(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jumpWord(input int target);
		return {mipsPkg::opJ, 26'(target)}; // word index since the program sits at 0
	endfunction

	function automatic logic [4:0] anyReg();
		return 5'($urandom_range(0, 7));
	endfunction

	function automatic logic [5:0] aluFunct();
		case ($urandom_range(0, 3))
			0:       return mipsPkg::functAdd;
			1:       return mipsPkg::functSub;
			2:       return mipsPkg::functAnd;
			default: return mipsPkg::functXor;
		endcase
	endfunction

	// forward targets keep every program finite
	function automatic int forwardTarget(input int idx);
		int target;
		target = idx + 1 + $urandom_range(0, 4);
		if (target > ProgLen - 1)
			target = ProgLen - 1;
		return target;
	endfunction

	task automatic buildProgram();
		int               kind;
		logic [4:0]       rs;
		logic [4:0]       rt;
		logic [15:0]      offset;
		for (int i = 0; i < `MEM_WORDS; i++)
		begin
			if (i >= DataBase)
				mem[i] = $urandom();
			else
				mem[i] = 32'h5a5a_0000 ^ (i << 2);
		end
		mem[DataBase] = 32'h0000_0c00;                                // base for r28
		mem[0] = immWord(mipsPkg::opLw, 5'd0, 5'd28, 16'h0800);
		for (int i = 1; i < ProgLen - 1; i++)
		begin
			kind = $urandom_range(0, 9);
			rs = anyReg();
			rt = anyReg();
			offset = 16'($urandom_range(0, 511) * 4 - 1024); // 0x800..0xffc from r28
			case (kind)
				0, 1, 2: mem[i] = rTypeWord(aluFunct(), rs, rt, anyReg());
				3:       mem[i] = rTypeWord(mipsPkg::functNop, rs, rt, anyReg());
				4:       mem[i] = immWord(mipsPkg::opLui, 5'd0, rt, 16'($urandom()));
				5:       mem[i] = immWord(mipsPkg::opLw, 5'd28, rt, offset);
				6:       mem[i] = immWord(mipsPkg::opSw, 5'd28, rt, offset);
				7, 8:
				begin
					if ($urandom_range(0, 2) == 0)
						rt = rs; // forces the compare result
					mem[i] = immWord((kind == 7) ? mipsPkg::opBeq : mipsPkg::opBne, rs, rt,
						16'(forwardTarget(i) - (i + 1)));
				end
				default: mem[i] = jumpWord(forwardTarget(i));
			endcase
		end
		mem[ProgLen - 1] = rTypeWord(mipsPkg::functBreak, 5'd0, 5'd0, 5'd0);
		for (int i = 0; i < WaitSlots; i++)
			waitPattern[i] = $urandom_range(0, 3);
	endtask

	// APB slave memory answering on the falling edge
	always @(negedge Clk)
	begin
		if (!arstN)
			apbRsp.pready = 1'b0;
		else if (apbReq.psel && !apbReq.penable)
		begin
			waitLeft = waitPattern[waitIdx];
			waitIdx = (waitIdx + 1) % WaitSlots;
			apbRsp.pready = 1'b0;
		end
		else if (apbReq.psel && apbReq.penable)
		begin
			if (waitLeft > 0)
			begin
				waitLeft--;
				apbRsp.pready = 1'b0;
			end
			else
			begin
				apbRsp.pready = 1'b1;
				if (apbReq.paddr >= `MEM_WORDS * 4 || apbReq.paddr[1:0] != 2'b00)
				begin
					tbErrors++;
					$display("ERROR at %0t ns: APB address %h lies outside the memory",
						$time, apbReq.paddr);
				end
				else if (apbReq.pwrite)
					mem[apbReq.paddr >> 2] = apbReq.pwdata;
				else
					apbRsp.prdata = mem[apbReq.paddr >> 2];
			end
		end
		else
			apbRsp.pready = 1'b0;
	end

	initial
	begin
		seed = 32'hc1b39faa;
		void'($urandom(seed));
		Clk = 1'b0;
		arstN = 1'b1;
		apbRsp = '0;
		waitIdx = 0;
		waitLeft = 0;
		tbErrors = 0;
		buildProgram();
		@(negedge Clk);
		arstN = 1'b0;
		repeat (5) @(negedge Clk);
		arstN = 1'b1;

		cycles = 0;
		while (!apbReq.psel && cycles < 2) // first setup phase
		begin
			@(negedge Clk);
			cycles++;
		end
		if (!apbReq.psel)
		begin
			tbErrors++;
			$display("ERROR at %0t ns: no APB setup phase within two cycles of reset release",
				$time);
		end

		cycles = 0;
		while (!halted && cycles < HaltTimeout)
		begin
			@(negedge Clk);
			cycles++;
		end
		if (!halted)
		begin
			tbErrors++;
			$display("ERROR at %0t ns: timed out after %0d cycles waiting for halted",
				$time, HaltTimeout);
		end

		repeat (50) @(negedge Clk); // bus must stay idle
		if (!breakSeen)
		begin
			tbErrors++;
			$display("ERROR at %0t ns: the reference model never reached BREAK", $time);
		end

		$display("checks: %0d, fetches: %0d, checker errors: %0d, testbench errors: %0d",
			checkCount, fetchCount, errorCount, tbErrors);
		if (errorCount + tbErrors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule : tbMipsCore

//--- project.f
+incdir+source
source/mipsPkg.sv
source/mipsControl.sv
source/regFile.sv
source/alu.sv
source/pcUnit.sv
source/busUnit.sv
source/mipsCore.sv
verif/mipsChecker.sv
verif/tbMipsCore.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mipsPkg.sv
      - source/mipsControl.sv
      - source/regFile.sv
      - source/alu.sv
      - source/pcUnit.sv
      - source/busUnit.sv
      - source/mipsCore.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/mipsChecker.sv
      - verif/tbMipsCore.sv
